//--- hw/rob_pkg.sv
/*
 * Shared widths, instruction types and the ROB entry layout for the commit backend.
 * Imported by the ROB and register state blocks.
 */
package rob_pkg;

    // data width of register and result values
    localparam int XLEN = 32;
    // 32 architectural registers, x0 hard zero
    localparam int REG_ADDR_W = 5;

    // dispatch instruction type
    typedef enum logic [2:0] {
        ALU    = 3'd0,
        LOAD   = 3'd1,
        STORE  = 3'd2,
        BRANCH = 3'd3,
        JUMP   = 3'd4
    } instr_type_e;

    // one ROB entry, 75 bits
    typedef struct packed {
        // slot holds an in-flight instruction
        logic                  valid;
        // speculative value present
        logic                  done;
        instr_type_e           instr_type;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc;
        // result, or store data for a STORE
        logic [XLEN-1:0]       spec_value;
        logic                  branch_taken;
    } rob_entry_t;

endpackage

//--- hw/rob_order_queue.sv
/*
 * Head/tail pointer queue of the ROB. Hands out allocation tags and
 * retire tags in program order; full and empty come from the pointers.
 */
`timescale 1ns/1ps

module rob_order_queue #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  logic             i_pop,
    output logic [TAG_W-1:0] o_tail_tag,
    output logic [TAG_W-1:0] o_head_tag,
    output logic             o_full,
    output logic             o_empty
);

    // pointers carry one extra wrap bit
    logic [TAG_W:0] head_ptr;
    logic [TAG_W:0] tail_ptr;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            // caller never pushes when full
            if (i_push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            // caller never pops when empty
            if (i_pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    // index bits are the tags
    assign o_tail_tag = tail_ptr[TAG_W-1:0];
    assign o_head_tag = head_ptr[TAG_W-1:0];

    // same index, different lap -> full
    assign o_full  = (tail_ptr[TAG_W] != head_ptr[TAG_W]) &&
                     (tail_ptr[TAG_W-1:0] == head_ptr[TAG_W-1:0]);
    // identical pointers -> empty
    assign o_empty = (tail_ptr == head_ptr);

endmodule

//--- hw/rob_entry_file.sv
/*
 * ROB entry storage. Dispatch writes new entries, the CDB fills results in place
 * and retire frees the head. Two lookup ports and one head port read combinationally.
 */
`timescale 1ns/1ps

module rob_entry_file #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    // dispatch write
    input  logic                       i_wr_en,
    input  logic [TAG_W-1:0]           i_wr_tag,
    input  rob_pkg::rob_entry_t        i_wr_entry,
    // cdb update
    input  logic                       i_cdb_valid,
    input  logic [TAG_W-1:0]           i_cdb_tag,
    input  logic [rob_pkg::XLEN-1:0]   i_cdb_data,
    input  logic                       i_cdb_branch_taken,
    // operand lookups
    input  logic [TAG_W-1:0]           i_lookup1_tag,
    input  logic [TAG_W-1:0]           i_lookup2_tag,
    // head and retire
    input  logic [TAG_W-1:0]           i_head_tag,
    input  logic                       i_retire,
    output rob_pkg::rob_entry_t        o_lookup1_entry,
    output rob_pkg::rob_entry_t        o_lookup2_entry,
    output rob_pkg::rob_entry_t        o_head_entry
);

    import rob_pkg::*;

    rob_entry_t entries [ROB_DEPTH];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            // only the status bits need clearing
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].done  <= 1'b0;
            end
        end else begin
            // new entry arrives valid, not done
            if (i_wr_en) begin
                entries[i_wr_tag] <= i_wr_entry;
            end
            // result lands in the tagged slot
            if (i_cdb_valid && entries[i_cdb_tag].valid) begin
                entries[i_cdb_tag].done         <= 1'b1;
                entries[i_cdb_tag].spec_value   <= i_cdb_data;
                entries[i_cdb_tag].branch_taken <= i_cdb_branch_taken;
            end
            // head slot is free again
            // never collides with a write, a full ROB refuses dispatch
            if (i_retire) begin
                entries[i_head_tag].valid <= 1'b0;
                entries[i_head_tag].done  <= 1'b0;
            end
        end
    end

    // read ports
    assign o_lookup1_entry = entries[i_lookup1_tag];
    assign o_lookup2_entry = entries[i_lookup2_tag];
    assign o_head_entry    = entries[i_head_tag];

endmodule

//--- hw/rob.sv
/*
 * Reorder buffer. Filters dispatch, builds entries, retires the head once it is
 * done and drives the retire outputs. Also answers the operand tag lookups.
 */
`timescale 1ns/1ps

module rob #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // dispatch
    input  logic                           i_dispatch_en,
    input  rob_pkg::instr_type_e           i_dispatch_type,
    input  logic [rob_pkg::REG_ADDR_W-1:0] i_dispatch_rd,
    input  logic [rob_pkg::XLEN-1:0]       i_dispatch_pc,
    // cdb
    input  logic                           i_cdb_valid,
    input  logic [TAG_W-1:0]               i_cdb_tag,
    input  logic [rob_pkg::XLEN-1:0]       i_cdb_data,
    input  logic                           i_cdb_branch_taken,
    // busy tags from the register state table
    input  logic [TAG_W-1:0]               i_rs1_tag,
    input  logic [TAG_W-1:0]               i_rs2_tag,
    output logic [TAG_W-1:0]               o_alloc_tag,
    output logic                           o_rob_full,
    output logic                           o_dispatch_mark,
    output logic                           o_rs1_done,
    output logic [rob_pkg::XLEN-1:0]       o_rs1_spec,
    output logic                           o_rs2_done,
    output logic [rob_pkg::XLEN-1:0]       o_rs2_spec,
    // retire
    output logic                           o_retire_valid,
    output logic [TAG_W-1:0]               o_retire_tag,
    output logic [rob_pkg::REG_ADDR_W-1:0] o_retire_rd,
    output rob_pkg::instr_type_e           o_retire_type,
    output logic [rob_pkg::XLEN-1:0]       o_retire_pc,
    output logic [rob_pkg::XLEN-1:0]       o_retire_data,
    output logic                           o_retire_branch,
    output logic                           o_retire_branch_taken,
    output logic                           o_retire_store_valid,
    output logic [rob_pkg::XLEN-1:0]       o_retire_store_data
);

    import rob_pkg::*;

    logic             q_full;
    logic             q_empty;
    logic             dispatch_ok;
    logic             retire;
    logic [TAG_W-1:0] head_tag;
    rob_entry_t       new_entry;
    rob_entry_t       head_entry;
    rob_entry_t       lookup1_entry;
    rob_entry_t       lookup2_entry;

    // jumps bypass the ROB entirely
    assign dispatch_ok = i_dispatch_en && (i_dispatch_type != JUMP) && !q_full;

    // head leaves as soon as its result is in
    assign retire = !q_empty && head_entry.valid && head_entry.done;

    rob_order_queue #(
        .ROB_DEPTH (ROB_DEPTH)
    ) order_queue_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_push     (dispatch_ok),
        .i_pop      (retire),
        .o_tail_tag (o_alloc_tag),
        .o_head_tag (head_tag),
        .o_full     (q_full),
        .o_empty    (q_empty)
    );

    // fresh entry, result still pending
    always_comb begin
        new_entry              = '0;
        new_entry.valid        = 1'b1;
        new_entry.instr_type   = i_dispatch_type;
        new_entry.rd           = i_dispatch_rd;
        new_entry.pc           = i_dispatch_pc;
    end

    rob_entry_file #(
        .ROB_DEPTH (ROB_DEPTH)
    ) entry_file_inst (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_wr_en            (dispatch_ok),
        .i_wr_tag           (o_alloc_tag),
        .i_wr_entry         (new_entry),
        .i_cdb_valid        (i_cdb_valid),
        .i_cdb_tag          (i_cdb_tag),
        .i_cdb_data         (i_cdb_data),
        .i_cdb_branch_taken (i_cdb_branch_taken),
        .i_lookup1_tag      (i_rs1_tag),
        .i_lookup2_tag      (i_rs2_tag),
        .i_head_tag         (head_tag),
        .i_retire           (retire),
        .o_lookup1_entry    (lookup1_entry),
        .o_lookup2_entry    (lookup2_entry),
        .o_head_entry       (head_entry)
    );

    assign o_rob_full      = q_full;
    assign o_dispatch_mark = dispatch_ok;

    // speculative operand forwarding
    assign o_rs1_done = lookup1_entry.valid && lookup1_entry.done;
    assign o_rs1_spec = lookup1_entry.spec_value;
    assign o_rs2_done = lookup2_entry.valid && lookup2_entry.done;
    assign o_rs2_spec = lookup2_entry.spec_value;

    // head fields straight out
    assign o_retire_valid = retire;
    assign o_retire_tag   = head_tag;
    assign o_retire_rd    = head_entry.rd;
    assign o_retire_type  = head_entry.instr_type;
    assign o_retire_pc    = head_entry.pc;
    assign o_retire_data  = head_entry.spec_value;

    // branch info only for branches
    assign o_retire_branch       = retire && (head_entry.instr_type == BRANCH);
    assign o_retire_branch_taken = o_retire_branch && head_entry.branch_taken;

    // store data only for stores
    assign o_retire_store_valid = retire && (head_entry.instr_type == STORE);
    assign o_retire_store_data  = (head_entry.instr_type == STORE) ? head_entry.spec_value : '0;

endmodule

//--- hw/reg_state_file.sv
/*
 * Architectural register state: committed values plus a busy bit and ROB tag
 * per register. Resolves source operands to a value or a tag to wait on.
 */
`timescale 1ns/1ps

module reg_state_file #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // accepted non-jump dispatch
    input  logic                           i_dispatch_mark,
    input  logic [rob_pkg::REG_ADDR_W-1:0] i_dispatch_rd,
    input  logic [TAG_W-1:0]               i_alloc_tag,
    // retire
    input  logic                           i_retire_valid,
    input  logic [TAG_W-1:0]               i_retire_tag,
    input  logic [rob_pkg::REG_ADDR_W-1:0] i_retire_rd,
    input  rob_pkg::instr_type_e           i_retire_type,
    input  logic [rob_pkg::XLEN-1:0]       i_retire_data,
    // operand lookups
    input  logic [rob_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rob_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic                           i_rs1_done,
    input  logic [rob_pkg::XLEN-1:0]       i_rs1_spec,
    input  logic                           i_rs2_done,
    input  logic [rob_pkg::XLEN-1:0]       i_rs2_spec,
    output logic [TAG_W-1:0]               o_rs1_tag,
    output logic [TAG_W-1:0]               o_rs2_tag,
    output logic                           o_rs1_ready,
    output logic [rob_pkg::XLEN-1:0]       o_rs1_value,
    output logic                           o_rs2_ready,
    output logic [rob_pkg::XLEN-1:0]       o_rs2_value
);

    import rob_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0]  reg_value [NUM_REGS];
    logic [TAG_W-1:0] reg_tag   [NUM_REGS];
    logic             reg_busy  [NUM_REGS];
    logic             retire_wr;

    // only ALU and LOAD results reach the register file
    assign retire_wr = i_retire_valid && (i_retire_rd != '0) &&
                       ((i_retire_type == ALU) || (i_retire_type == LOAD));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                reg_value[i] <= '0;
                reg_tag[i]   <= '0;
                reg_busy[i]  <= 1'b0;
            end
        end else begin
            if (retire_wr) begin
                reg_value[i_retire_rd] <= i_retire_data;
            end
            // release only if no younger producer took the register over
            if (i_retire_valid && (i_retire_tag == reg_tag[i_retire_rd])) begin
                reg_busy[i_retire_rd] <= 1'b0;
            end
            // later assignment, so dispatch beats a same-cycle retire
            if (i_dispatch_mark && (i_dispatch_rd != '0)) begin
                reg_busy[i_dispatch_rd] <= 1'b1;
                reg_tag[i_dispatch_rd]  <= i_alloc_tag;
            end
        end
    end

    // tags go to the ROB for the done/spec lookup
    assign o_rs1_tag = reg_tag[i_rs1];
    assign o_rs2_tag = reg_tag[i_rs2];

    // not busy -> committed, busy and done -> speculative, else wait on tag
    assign o_rs1_ready = !reg_busy[i_rs1] || i_rs1_done;
    assign o_rs1_value = reg_busy[i_rs1] ? i_rs1_spec : reg_value[i_rs1];
    assign o_rs2_ready = !reg_busy[i_rs2] || i_rs2_done;
    assign o_rs2_value = reg_busy[i_rs2] ? i_rs2_spec : reg_value[i_rs2];

endmodule

//--- hw/rob_core_top.sv
/*
 * Commit backend top level. Joins the ROB and the register state table;
 * ROB_DEPTH is set here and passed down.
 */
`timescale 1ns/1ps

module rob_core_top #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // dispatch
    input  logic                           i_dispatch_en,
    input  rob_pkg::instr_type_e           i_dispatch_type,
    input  logic [rob_pkg::REG_ADDR_W-1:0] i_dispatch_rd,
    input  logic [rob_pkg::XLEN-1:0]       i_dispatch_pc,
    output logic [TAG_W-1:0]               o_alloc_tag,
    output logic                           o_rob_full,
    // cdb
    input  logic                           i_cdb_valid,
    input  logic [TAG_W-1:0]               i_cdb_tag,
    input  logic [rob_pkg::XLEN-1:0]       i_cdb_data,
    input  logic                           i_cdb_branch_taken,
    // operand lookups
    input  logic [rob_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rob_pkg::REG_ADDR_W-1:0] i_rs2,
    output logic                           o_rs1_ready,
    output logic [rob_pkg::XLEN-1:0]       o_rs1_value,
    output logic [TAG_W-1:0]               o_rs1_tag,
    output logic                           o_rs2_ready,
    output logic [rob_pkg::XLEN-1:0]       o_rs2_value,
    output logic [TAG_W-1:0]               o_rs2_tag,
    // retire
    output logic                           o_retire_valid,
    output logic [TAG_W-1:0]               o_retire_tag,
    output logic [rob_pkg::REG_ADDR_W-1:0] o_retire_rd,
    output rob_pkg::instr_type_e           o_retire_type,
    output logic [rob_pkg::XLEN-1:0]       o_retire_pc,
    output logic [rob_pkg::XLEN-1:0]       o_retire_data,
    output logic                           o_retire_branch,
    output logic                           o_retire_branch_taken,
    output logic                           o_retire_store_valid,
    output logic [rob_pkg::XLEN-1:0]       o_retire_store_data
);

    logic                     dispatch_mark;
    logic                     rs1_done;
    logic                     rs2_done;
    logic [rob_pkg::XLEN-1:0] rs1_spec;
    logic [rob_pkg::XLEN-1:0] rs2_spec;

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) rob_inst (
        .i_clk                 (i_clk),
        .i_rst_n               (i_rst_n),
        .i_dispatch_en         (i_dispatch_en),
        .i_dispatch_type       (i_dispatch_type),
        .i_dispatch_rd         (i_dispatch_rd),
        .i_dispatch_pc         (i_dispatch_pc),
        .i_cdb_valid           (i_cdb_valid),
        .i_cdb_tag             (i_cdb_tag),
        .i_cdb_data            (i_cdb_data),
        .i_cdb_branch_taken    (i_cdb_branch_taken),
        .i_rs1_tag             (o_rs1_tag),
        .i_rs2_tag             (o_rs2_tag),
        .o_alloc_tag           (o_alloc_tag),
        .o_rob_full            (o_rob_full),
        .o_dispatch_mark       (dispatch_mark),
        .o_rs1_done            (rs1_done),
        .o_rs1_spec            (rs1_spec),
        .o_rs2_done            (rs2_done),
        .o_rs2_spec            (rs2_spec),
        .o_retire_valid        (o_retire_valid),
        .o_retire_tag          (o_retire_tag),
        .o_retire_rd           (o_retire_rd),
        .o_retire_type         (o_retire_type),
        .o_retire_pc           (o_retire_pc),
        .o_retire_data         (o_retire_data),
        .o_retire_branch       (o_retire_branch),
        .o_retire_branch_taken (o_retire_branch_taken),
        .o_retire_store_valid  (o_retire_store_valid),
        .o_retire_store_data   (o_retire_store_data)
    );

    reg_state_file #(
        .ROB_DEPTH (ROB_DEPTH)
    ) reg_state_inst (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_dispatch_mark (dispatch_mark),
        .i_dispatch_rd   (i_dispatch_rd),
        .i_alloc_tag     (o_alloc_tag),
        .i_retire_valid  (o_retire_valid),
        .i_retire_tag    (o_retire_tag),
        .i_retire_rd     (o_retire_rd),
        .i_retire_type   (o_retire_type),
        .i_retire_data   (o_retire_data),
        .i_rs1           (i_rs1),
        .i_rs2           (i_rs2),
        .i_rs1_done      (rs1_done),
        .i_rs1_spec      (rs1_spec),
        .i_rs2_done      (rs2_done),
        .i_rs2_spec      (rs2_spec),
        .o_rs1_tag       (o_rs1_tag),
        .o_rs2_tag       (o_rs2_tag),
        .o_rs1_ready     (o_rs1_ready),
        .o_rs1_value     (o_rs1_value),
        .o_rs2_ready     (o_rs2_ready),
        .o_rs2_value     (o_rs2_value)
    );

endmodule

//--- tb/rob_core_chk.sv
/*
 * Concurrent checks on the commit backend top level.
 * Attached to every rob_core_top instance by the bind at the end.
 */
`timescale 1ns/1ps

module rob_core_chk #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input logic                 i_clk,
    input logic                 i_rst_n,
    input logic                 i_dispatch_en,
    input rob_pkg::instr_type_e i_dispatch_type,
    input logic [TAG_W-1:0]     i_alloc_tag,
    input logic                 i_rob_full,
    input logic                 i_retire_valid,
    input rob_pkg::instr_type_e i_retire_type,
    input logic                 i_retire_store_valid
);

    import rob_pkg::*;

    logic dispatch_accepted;

    // jumps and dispatch into a full ROB take no tag
    assign dispatch_accepted = i_dispatch_en && (i_dispatch_type != JUMP) && !i_rob_full;

    a_no_retire_in_reset: assert property (
        @(posedge i_clk) !i_rst_n |-> !$rose(i_retire_valid)
    ) else $error("retire pulse rose during reset");

    a_store_qualified: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_retire_store_valid |-> (i_retire_valid && (i_retire_type == STORE))
    ) else $error("store valid without a retiring store");

    // tag moves only after an accepted dispatch
    a_alloc_tag_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !dispatch_accepted |=> $stable(i_alloc_tag)
    ) else $error("allocation tag moved without an accepted dispatch");

endmodule

bind rob_core_top rob_core_chk #(
    .ROB_DEPTH (ROB_DEPTH)
) chk_inst (
    .i_clk                (i_clk),
    .i_rst_n              (i_rst_n),
    .i_dispatch_en        (i_dispatch_en),
    .i_dispatch_type      (i_dispatch_type),
    .i_alloc_tag          (o_alloc_tag),
    .i_rob_full           (o_rob_full),
    .i_retire_valid       (o_retire_valid),
    .i_retire_type        (o_retire_type),
    .i_retire_store_valid (o_retire_store_valid)
);

//--- tb/rob_core_tb.sv
/*
 * Testbench for the commit backend top level. Drives dispatch, CDB and lookups,
 * keeps a reference model and compares every output on each rising clock edge.
 */
`timescale 1ns/1ps

module rob_core_tb;

    import rob_pkg::*;

    localparam int ROB_DEPTH = 8;
    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int NUM_REGS = 2 ** REG_ADDR_W;
    // dispatches plus broadcasts, sets the watchdog budget
    localparam int NUM_OPS = 60;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_dispatch_en;
    instr_type_e           i_dispatch_type;
    logic [REG_ADDR_W-1:0] i_dispatch_rd;
    logic [XLEN-1:0]       i_dispatch_pc;
    logic [TAG_W-1:0]      o_alloc_tag;
    logic                  o_rob_full;
    logic                  i_cdb_valid;
    logic [TAG_W-1:0]      i_cdb_tag;
    logic [XLEN-1:0]       i_cdb_data;
    logic                  i_cdb_branch_taken;
    logic [REG_ADDR_W-1:0] i_rs1;
    logic [REG_ADDR_W-1:0] i_rs2;
    logic                  o_rs1_ready;
    logic [XLEN-1:0]       o_rs1_value;
    logic [TAG_W-1:0]      o_rs1_tag;
    logic                  o_rs2_ready;
    logic [XLEN-1:0]       o_rs2_value;
    logic [TAG_W-1:0]      o_rs2_tag;
    logic                  o_retire_valid;
    logic [TAG_W-1:0]      o_retire_tag;
    logic [REG_ADDR_W-1:0] o_retire_rd;
    instr_type_e           o_retire_type;
    logic [XLEN-1:0]       o_retire_pc;
    logic [XLEN-1:0]       o_retire_data;
    logic                  o_retire_branch;
    logic                  o_retire_branch_taken;
    logic                  o_retire_store_valid;
    logic [XLEN-1:0]       o_retire_store_data;

    // reference model, register side
    logic [XLEN-1:0]       m_reg_val  [NUM_REGS];
    logic                  m_reg_busy [NUM_REGS];
    logic [TAG_W-1:0]      m_reg_tag  [NUM_REGS];
    // reference model, ROB side
    logic                  m_valid [ROB_DEPTH];
    logic                  m_done  [ROB_DEPTH];
    instr_type_e           m_type  [ROB_DEPTH];
    logic [REG_ADDR_W-1:0] m_rd    [ROB_DEPTH];
    logic [XLEN-1:0]       m_pc    [ROB_DEPTH];
    logic [XLEN-1:0]       m_val   [ROB_DEPTH];
    logic                  m_taken [ROB_DEPTH];
    int                    m_head;
    int                    m_tail;
    int                    m_count;
    int                    accepted;
    int                    retired;
    int                    pc_next;
    integer                seed;
    logic [TAG_W-1:0]      pending [$];

    rob_core_top #(
        .ROB_DEPTH (ROB_DEPTH)
    ) rob_core_inst (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    // not busy -> committed, busy and done -> speculative, else wait on tag
    task automatic compare_lookup(input string name, input logic [REG_ADDR_W-1:0] rs,
                                  input logic ready, input logic [XLEN-1:0] value,
                                  input logic [TAG_W-1:0] tag);
        if (!m_reg_busy[rs]) begin
            compare_value({name, "_ready"}, ready, 1'b1);
            compare_value({name, "_value"}, value, m_reg_val[rs]);
        end else if (m_done[m_reg_tag[rs]]) begin
            compare_value({name, "_ready"}, ready, 1'b1);
            compare_value({name, "_value"}, value, m_val[m_reg_tag[rs]]);
        end else begin
            compare_value({name, "_ready"}, ready, 1'b0);
            compare_value({name, "_tag"}, tag, m_reg_tag[rs]);
        end
    endtask

    task automatic reset_model();
        for (int r = 0; r < NUM_REGS; r++) begin
            m_reg_val[r]  = '0;
            m_reg_busy[r] = 1'b0;
            m_reg_tag[r]  = '0;
        end
        for (int e = 0; e < ROB_DEPTH; e++) begin
            m_valid[e] = 1'b0;
            m_done[e]  = 1'b0;
        end
        m_head   = 0;
        m_tail   = 0;
        m_count  = 0;
        accepted = 0;
        retired  = 0;
    endtask

    task automatic compare_outputs();
        int   h;
        logic exp_retire;
        h = m_head % ROB_DEPTH;
        // head retires once it is done
        exp_retire = (m_count > 0) && m_done[h];
        compare_value("o_alloc_tag", o_alloc_tag, m_tail % ROB_DEPTH);
        compare_value("o_rob_full", o_rob_full, m_count == ROB_DEPTH);
        compare_value("o_retire_valid", o_retire_valid, exp_retire);
        if (exp_retire) begin
            compare_value("o_retire_tag", o_retire_tag, h);
            compare_value("o_retire_rd", o_retire_rd, m_rd[h]);
            compare_value("o_retire_type", o_retire_type, m_type[h]);
            compare_value("o_retire_pc", o_retire_pc, m_pc[h]);
            compare_value("o_retire_data", o_retire_data, m_val[h]);
            compare_value("o_retire_branch", o_retire_branch, m_type[h] == BRANCH);
            compare_value("o_retire_branch_taken", o_retire_branch_taken,
                          (m_type[h] == BRANCH) && m_taken[h]);
            compare_value("o_retire_store_valid", o_retire_store_valid, m_type[h] == STORE);
            compare_value("o_retire_store_data", o_retire_store_data,
                          (m_type[h] == STORE) ? m_val[h] : '0);
            retired++;
        end else begin
            compare_value("o_retire_store_valid", o_retire_store_valid, 1'b0);
            compare_value("o_retire_branch", o_retire_branch, 1'b0);
        end
        compare_lookup("o_rs1", i_rs1, o_rs1_ready, o_rs1_value, o_rs1_tag);
        compare_lookup("o_rs2", i_rs2, o_rs2_ready, o_rs2_value, o_rs2_tag);
    endtask

    task automatic update_model();
        int   h;
        int   t;
        logic full_before;
        h = m_head % ROB_DEPTH;
        t = m_tail % ROB_DEPTH;
        // a slot freed by retire is usable only from the next cycle
        full_before = (m_count == ROB_DEPTH);
        if ((m_count > 0) && m_done[h]) begin
            if (((m_type[h] == ALU) || (m_type[h] == LOAD)) && (m_rd[h] != '0)) begin
                m_reg_val[m_rd[h]] = m_val[h];
            end
            if (m_reg_tag[m_rd[h]] == h) begin
                m_reg_busy[m_rd[h]] = 1'b0;
            end
            m_valid[h] = 1'b0;
            m_done[h]  = 1'b0;
            m_head++;
            m_count--;
        end
        if (i_cdb_valid && m_valid[i_cdb_tag]) begin
            m_done[i_cdb_tag]  = 1'b1;
            m_val[i_cdb_tag]   = i_cdb_data;
            m_taken[i_cdb_tag] = i_cdb_branch_taken;
        end
        // after retire, so a same-cycle dispatch keeps the register busy
        if (i_dispatch_en && (i_dispatch_type != JUMP) && !full_before) begin
            m_valid[t] = 1'b1;
            m_done[t]  = 1'b0;
            m_type[t]  = i_dispatch_type;
            m_rd[t]    = i_dispatch_rd;
            m_pc[t]    = i_dispatch_pc;
            m_val[t]   = '0;
            m_taken[t] = 1'b0;
            if (i_dispatch_rd != '0) begin
                m_reg_busy[i_dispatch_rd] = 1'b1;
                m_reg_tag[i_dispatch_rd]  = t;
            end
            m_tail++;
            m_count++;
            accepted++;
        end
    endtask

    // pre-edge values, inputs only move on the falling edge
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            reset_model();
        end else begin
            compare_outputs();
            update_model();
        end
    end

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            i_dispatch_en = 1'b0;
            i_cdb_valid   = 1'b0;
        end
    endtask

    // tag is what the model expects this dispatch to receive
    task automatic dispatch_instr(input instr_type_e kind, input logic [REG_ADDR_W-1:0] rd,
                                  output logic [TAG_W-1:0] tag);
        @(negedge i_clk);
        tag             = m_tail % ROB_DEPTH;
        i_dispatch_en   = 1'b1;
        i_dispatch_type = kind;
        i_dispatch_rd   = rd;
        i_dispatch_pc   = pc_next;
        i_cdb_valid     = 1'b0;
        pc_next         = pc_next + 4;
    endtask

    task automatic broadcast(input logic [TAG_W-1:0] tag, input logic taken);
        @(negedge i_clk);
        i_dispatch_en      = 1'b0;
        i_cdb_valid        = 1'b1;
        i_cdb_tag          = tag;
        i_cdb_data         = $random(seed);
        i_cdb_branch_taken = taken;
    endtask

    // finish the pending tags in random order, random gaps
    task automatic complete_random();
        int               idx;
        logic [TAG_W-1:0] tag;
        while (pending.size() > 0) begin
            idx = $unsigned($random(seed)) % pending.size();
            tag = pending[idx];
            pending.delete(idx);
            broadcast(tag, 1'b0);
            if ($random(seed) & 1) begin
                drive_idle(1);
            end
        end
    endtask

    // wait until every accepted entry has shown a retire pulse
    task automatic drain_rob();
        drive_idle(1);
        while (retired != accepted) begin
            @(negedge i_clk);
        end
    endtask

    initial begin
        logic [TAG_W-1:0] tag;
        logic [TAG_W-1:0] tag_young;
        seed               = 32'ha7ff;
        pc_next            = 32'h0000_1000;
        i_rst_n            = 1'b0;
        i_dispatch_en      = 1'b0;
        i_dispatch_type    = ALU;
        i_dispatch_rd      = '0;
        i_dispatch_pc      = '0;
        i_cdb_valid        = 1'b0;
        i_cdb_tag          = '0;
        i_cdb_data         = '0;
        i_cdb_branch_taken = 1'b0;
        i_rs1              = '0;
        i_rs2              = '0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        // reset state, every register looked up
        for (int r = 0; r < NUM_REGS; r++) begin
            @(negedge i_clk);
            i_rs1 = REG_ADDR_W'(r);
            i_rs2 = REG_ADDR_W'(NUM_REGS - 1 - r);
        end

        // busy with tag, then speculative, then committed
        i_rs1 = 5'd5;
        i_rs2 = 5'd6;
        dispatch_instr(ALU, 5'd5, tag);
        drive_idle(2);
        broadcast(tag, 1'b0);
        drive_idle(3);

        // in-order retire with out-of-order completion
        for (int k = 0; k < 6; k++) begin
            dispatch_instr((k % 2) ? LOAD : ALU, REG_ADDR_W'(k + 1), tag);
            pending.push_back(tag);
        end
        i_rs1 = 5'd1;
        i_rs2 = 5'd4;
        complete_random();
        drain_rob();

        // fill the ROB, then refused dispatch and a jump, both aimed at watched x22
        i_rs1 = 5'd10;
        i_rs2 = 5'd22;
        for (int k = 0; k < ROB_DEPTH; k++) begin
            dispatch_instr(ALU, REG_ADDR_W'(10 + k), tag);
            pending.push_back(tag);
        end
        dispatch_instr(ALU, 5'd22, tag);
        dispatch_instr(JUMP, 5'd22, tag);
        // still full in the retire cycle, free one cycle later
        broadcast(pending.pop_front(), 1'b0);
        dispatch_instr(ALU, 5'd22, tag);
        dispatch_instr(ALU, 5'd22, tag);
        pending.push_back(tag);
        complete_random();
        drain_rob();

        // store leaves the committed value of x7 alone
        i_rs1 = 5'd7;
        i_rs2 = 5'd0;
        dispatch_instr(ALU, 5'd7, tag);
        broadcast(tag, 1'b0);
        drain_rob();
        // jump with room in the ROB, no tag taken and x7 not marked
        dispatch_instr(JUMP, 5'd7, tag);
        dispatch_instr(STORE, 5'd7, tag);
        broadcast(tag, 1'b0);
        drain_rob();
        dispatch_instr(BRANCH, 5'd0, tag);
        broadcast(tag, 1'b1);
        drain_rob();
        // x0 stays zero
        dispatch_instr(ALU, 5'd0, tag);
        broadcast(tag, 1'b0);
        drain_rob();

        // younger producer keeps x9 busy past the older retire
        i_rs1 = 5'd9;
        dispatch_instr(ALU, 5'd9, tag);
        dispatch_instr(ALU, 5'd9, tag_young);
        broadcast(tag, 1'b0);
        drive_idle(3);
        broadcast(tag_young, 1'b0);
        drain_rob();

        // dispatch to x9 in the very cycle its older producer retires
        dispatch_instr(ALU, 5'd9, tag);
        broadcast(tag, 1'b0);
        dispatch_instr(ALU, 5'd9, tag_young);
        broadcast(tag_young, 1'b0);
        drain_rob();

        drive_idle(2);
        $display("Finished with no errors");
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_OPS * 10 + 100) @(posedge i_clk);
        $display("timeout: the run did not finish within %0d cycles", NUM_OPS * 10 + 100);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- vlog.f
hw/rob_pkg.sv
hw/rob_order_queue.sv
hw/rob_entry_file.sv
hw/rob.sv
hw/reg_state_file.sv
hw/rob_core_top.sv
tb/rob_core_chk.sv
tb/rob_core_tb.sv
